// File: rtl/fifo_pkg.sv
package fifo_pkg;

  // memory geometry
  localparam int DEPTH  = 8;          // words held by the FIFO
  localparam int ADDR_W = 3;          // log2 of DEPTH
  localparam int PTR_W  = ADDR_W + 1; // extra lap bit tells full from empty
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;  // memory address
  typedef logic [PTR_W-1:0]  ptr_t;   // binary or gray pointer, lap bit on top
  typedef logic [DATA_W-1:0] data_t;  // one FIFO word

  // write port of the memory, lives in the wclk domain
  typedef struct packed {
    logic  wen;    // push accepted at this wclk edge
    addr_t waddr;
    data_t wdata;
  } ram_wr_t;

  // read port of the memory, lives in the rclk domain
  typedef struct packed {
    logic  ren;    // pop accepted at this rclk edge
    addr_t raddr;  // head of the queue
  } ram_rd_t;

endpackage

// File: rtl/fifo_push.sv
`timescale 1ns/1ps

module fifo_push (
  input  logic            wclk,
  input  logic            fflush,
  input  logic            push,
  input  fifo_pkg::ptr_t  rd_gray,     // read pointer after the wclk synchronizer
  output fifo_pkg::ptr_t  wr_gray,
  output fifo_pkg::addr_t waddr,
  output logic            wen,
  output logic            full,
  output logic            almost_full
);

  fifo_pkg::ptr_t wr_bin;       // binary write pointer
  fifo_pkg::ptr_t wr_bin_next;
  fifo_pkg::ptr_t rd_bin;       // read pointer back in binary
  fifo_pkg::ptr_t free_next;    // free slots once this edge has passed

  // a push while full is simply dropped
  assign wen = push & ~full;

  assign wr_bin_next = wr_bin + fifo_pkg::ptr_t'(wen);

  // gray to binary
  // each binary bit is the xor of the gray bits at and above it
  always_comb begin
    for (int i = 0; i < fifo_pkg::PTR_W; i++) begin
      rd_bin[i] = ^(rd_gray >> i);
    end
  end

  // pessimistic, the read pointer seen here lags the real one
  assign free_next = fifo_pkg::ptr_t'(fifo_pkg::DEPTH) - (wr_bin_next - rd_bin);

  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_bin_next ^ (wr_bin_next >> 1); // published to the read side
    end
  end

  // flags come from the next-state count, so they match the pointer after the edge
  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      full        <= 1'b0;
      almost_full <= 1'b0;
    end else begin
      full        <= (free_next == '0);
      almost_full <= (free_next == fifo_pkg::ptr_t'(1)); // one slot left
    end
  end

  assign waddr = wr_bin[fifo_pkg::ADDR_W-1:0];

  // the writer never gets more than DEPTH words ahead of the reader,
  // which holds only if full and the crossing work together
  a_no_overflow: assert property (
    @(posedge wclk) disable iff (fflush)
    fifo_pkg::ptr_t'(wr_bin - rd_bin) <= fifo_pkg::ptr_t'(fifo_pkg::DEPTH)
  ) else $error("fifo_push: write pointer overran the read pointer");

  // safe crossing needs a single bit change per edge
  a_gray_step: assert property (
    @(posedge wclk) disable iff (fflush)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else $error("fifo_push: write gray pointer moved more than one bit");

endmodule

// File: rtl/fifo_pop.sv
`timescale 1ns/1ps

module fifo_pop (
  input  logic            rclk,
  input  logic            fflush,
  input  logic            pop,
  input  fifo_pkg::ptr_t  wr_gray,     // write pointer after the rclk synchronizer
  output fifo_pkg::ptr_t  rd_gray,
  output fifo_pkg::addr_t raddr,
  output logic            ren,
  output logic            empty,
  output logic            almost_empty
);

  fifo_pkg::ptr_t rd_bin;       // binary read pointer
  fifo_pkg::ptr_t rd_bin_next;
  fifo_pkg::ptr_t wr_bin;       // write pointer back in binary
  fifo_pkg::ptr_t used_next;    // words left once this edge has passed

  // a pop while empty is ignored
  assign ren = pop & ~empty;

  assign rd_bin_next = rd_bin + fifo_pkg::ptr_t'(ren);

  always_comb begin
    for (int i = 0; i < fifo_pkg::PTR_W; i++) begin
      wr_bin[i] = ^(wr_gray >> i); // gray to binary
    end
  end

  // modular difference, the lap bit keeps DEPTH apart from zero
  assign used_next = wr_bin - rd_bin_next;

  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
    end
  end

  // empty comes out of reset set, nothing has been written yet
  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      empty        <= 1'b1;
      almost_empty <= 1'b0;
    end else begin
      empty        <= (used_next == '0);
      almost_empty <= (used_next == fifo_pkg::ptr_t'(1)); // last word stored
    end
  end

  // memory reads the current head, the pointer moves on at the same edge
  assign raddr = rd_bin[fifo_pkg::ADDR_W-1:0];

  // the reader never passes the writer, a pass would wrap the
  // difference past DEPTH
  a_no_underflow: assert property (
    @(posedge rclk) disable iff (fflush)
    fifo_pkg::ptr_t'(wr_bin - rd_bin) <= fifo_pkg::ptr_t'(fifo_pkg::DEPTH)
  ) else $error("fifo_pop: read pointer passed the write pointer");

  a_gray_step: assert property (
    @(posedge rclk) disable iff (fflush)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else $error("fifo_pop: read gray pointer moved more than one bit");

endmodule

// File: rtl/fifo_ctl.sv
`timescale 1ns/1ps

module fifo_ctl (
  input  logic            wclk,
  input  logic            rclk,
  input  logic            fflush,
  input  logic            push,
  input  logic            pop,
  output fifo_pkg::addr_t waddr,
  output fifo_pkg::addr_t raddr,
  output logic            wen,
  output logic            ren,
  output logic            full,
  output logic            almost_full,
  output logic            empty,
  output logic            almost_empty
);

  fifo_pkg::ptr_t wr_gray;       // from the push side, wclk domain
  fifo_pkg::ptr_t rd_gray;       // from the pop side, rclk domain
  fifo_pkg::ptr_t wr_gray_meta;  // first rclk stage
  fifo_pkg::ptr_t wr_gray_sync;
  fifo_pkg::ptr_t rd_gray_meta;  // first wclk stage
  fifo_pkg::ptr_t rd_gray_sync;

  // write pointer into the read domain
  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  // read pointer into the write domain
  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  fifo_push u_fifo_push (
    .wclk        (wclk),
    .fflush      (fflush),
    .push        (push),
    .rd_gray     (rd_gray_sync),
    .wr_gray     (wr_gray),
    .waddr       (waddr),
    .wen         (wen),
    .full        (full),
    .almost_full (almost_full)
  );

  fifo_pop u_fifo_pop (
    .rclk         (rclk),
    .fflush       (fflush),
    .pop          (pop),
    .wr_gray      (wr_gray_sync),
    .rd_gray      (rd_gray),
    .raddr        (raddr),
    .ren          (ren),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

endmodule

// File: rtl/fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
  input  logic              wclk,
  input  logic              rclk,
  input  fifo_pkg::ram_wr_t wr,
  input  fifo_pkg::ram_rd_t rd,
  output fifo_pkg::data_t   rdata
);

  fifo_pkg::data_t mem [fifo_pkg::DEPTH];

  // write side, the word lands at the edge that accepts the push
  always_ff @(posedge wclk) begin
    if (wr.wen) begin
      mem[wr.waddr] <= wr.wdata;
    end
  end

  // registered read of the head word
  // rdata holds its value between pops
  always_ff @(posedge rclk) begin
    if (rd.ren) begin
      rdata <= mem[rd.raddr];
    end
  end

endmodule

// File: rtl/async_fifo.sv
`timescale 1ns/1ps

module async_fifo (
  // write domain
  input  logic            wclk,
  input  logic            push,
  input  fifo_pkg::data_t wdata,
  output logic            full,
  output logic            almost_full,
  // read domain
  input  logic            rclk,
  input  logic            pop,
  output fifo_pkg::data_t rdata,
  output logic            empty,
  output logic            almost_empty,
  input  logic            fflush     // clears both domains
);

  fifo_pkg::addr_t   waddr;
  fifo_pkg::addr_t   raddr;
  logic              wen;
  logic              ren;
  fifo_pkg::ram_wr_t wr_port;
  fifo_pkg::ram_rd_t rd_port;

  fifo_ctl u_fifo_ctl (
    .wclk         (wclk),
    .rclk         (rclk),
    .fflush       (fflush),
    .push         (push),
    .pop          (pop),
    .waddr        (waddr),
    .raddr        (raddr),
    .wen          (wen),
    .ren          (ren),
    .full         (full),
    .almost_full  (almost_full),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  assign wr_port = '{wen: wen, waddr: waddr, wdata: wdata};
  assign rd_port = '{ren: ren, raddr: raddr};

  fifo_ram u_fifo_ram (
    .wclk  (wclk),
    .rclk  (rclk),
    .wr    (wr_port),
    .rd    (rd_port),
    .rdata (rdata)
  );

endmodule

// File: verification/async_fifo_tb.sv
`timescale 1ns/1ps

module async_fifo_tb;

  localparam int SETTLE_CYCLES  = 6;    // rclk cycles for a flag to cross domains
  localparam int TRAFFIC_CYCLES = 200;  // wclk cycles of random traffic
  localparam int WRAP_LAPS      = 3;
  // all tests take a few hundred rclk cycles, so this bound leaves wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic            wclk;
  logic            rclk;
  logic            fflush;
  logic            push;
  logic            pop;
  fifo_pkg::data_t wdata;
  fifo_pkg::data_t rdata;
  logic            full;
  logic            almost_full;
  logic            empty;
  logic            almost_empty;

  fifo_pkg::data_t ref_q[$];  // words expected on rdata, oldest first
  int              error_count = 0;
  int              check_count = 0;
  int              cycle_count = 0;

  async_fifo u_dut (
    .wclk         (wclk),
    .push         (push),
    .wdata        (wdata),
    .full         (full),
    .almost_full  (almost_full),
    .rclk         (rclk),
    .pop          (pop),
    .rdata        (rdata),
    .empty        (empty),
    .almost_empty (almost_empty),
    .fflush       (fflush)
  );

  always #15 wclk = ~wclk;  // 30 ns write clock
  always #20 rclk = ~rclk;  // 40 ns read clock

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("Error: %s", what);
  endtask

  task automatic settle;
    repeat (SETTLE_CYCLES) @(negedge rclk);
  endtask

  // one push strobe, accepted only when full is low at the edge
  task automatic push_word(input fifo_pkg::data_t word, output logic accepted);
    @(negedge wclk);
    push     = 1'b1;
    wdata    = word;
    accepted = ~full;  // full only moves on the rising edge
    if (accepted) begin
      ref_q.push_back(word);
    end
    @(negedge wclk);
    push = 1'b0;
  endtask

  task automatic compare_head(input string name);
    fifo_pkg::data_t expected;
    if (ref_q.size() == 0) begin
      report_error("a word was popped that the reference queue does not hold");
    end else begin
      expected = ref_q.pop_front();
      check(name, 32'(expected), 32'(rdata));
    end
  endtask

  // one pop strobe, the head word shows on rdata after the accepting edge
  task automatic pop_word(input string name, output logic accepted);
    @(negedge rclk);
    pop      = 1'b1;
    accepted = ~empty;
    @(negedge rclk);
    pop = 1'b0;
    if (accepted) begin
      compare_head(name);
    end
  endtask

  task automatic drain_all(input string name);
    logic accepted;
    int   guard;
    guard = 0;
    settle;
    while (!empty && guard < 2 * fifo_pkg::DEPTH) begin
      pop_word(name, accepted);
      guard++;
    end
    settle;
    check(name, 32'd1, 32'(empty));
    check(name, 32'd0, 32'(ref_q.size()));  // nothing left behind
  endtask

  task automatic reset_test;
    settle;
    check("reset empty", 32'd1, 32'(empty));
    check("reset full", 32'd0, 32'(full));
    check("reset almost_full", 32'd0, 32'(almost_full));
    check("reset almost_empty", 32'd0, 32'(almost_empty));
  endtask

  task automatic fill_test;
    logic accepted;
    for (int i = 0; i < fifo_pkg::DEPTH - 1; i++) begin
      push_word(fifo_pkg::data_t'($urandom), accepted);
      check("fill accept", 32'd1, 32'(accepted));
    end
    check("fill almost_full", 32'd1, 32'(almost_full));
    check("fill full early", 32'd0, 32'(full));
    push_word(fifo_pkg::data_t'($urandom), accepted);  // last free slot
    check("fill accept", 32'd1, 32'(accepted));
    check("fill full", 32'd1, 32'(full));
    check("fill almost_full at full", 32'd0, 32'(almost_full));
    push_word(fifo_pkg::data_t'($urandom), accepted);  // dropped
    check("fill push while full", 32'd0, 32'(accepted));
    check("fill full held", 32'd1, 32'(full));
  endtask

  task automatic drain_test;
    logic accepted;
    settle;
    check("drain not empty", 32'd0, 32'(empty));
    for (int i = 0; i < fifo_pkg::DEPTH - 1; i++) begin
      pop_word("drain data", accepted);
      check("drain accept", 32'd1, 32'(accepted));
    end
    settle;
    check("drain almost_empty", 32'd1, 32'(almost_empty));
    check("drain one word left", 32'd0, 32'(empty));
    pop_word("drain data", accepted);
    settle;
    check("drain empty", 32'd1, 32'(empty));
    check("drain almost_empty cleared", 32'd0, 32'(almost_empty));
    pop_word("drain pop while empty", accepted);
    check("drain pop while empty", 32'd0, 32'(accepted));
    check("drain leftover", 32'd0, 32'(ref_q.size()));
    check("drain full released", 32'd0, 32'(full));
  endtask

  // both domains run free, each strobe with a one in two chance
  task automatic traffic_test;
    logic [31:0] wr_rnd;
    logic [31:0] rd_rnd;
    logic        pending;
    fork
      begin
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
          @(negedge wclk);
          wr_rnd = $urandom;
          push   = wr_rnd[0];
          wdata  = fifo_pkg::data_t'($urandom);
          if (push && !full) begin
            ref_q.push_back(wdata);
          end
        end
        @(negedge wclk);
        push = 1'b0;
      end
      begin
        pending = 1'b0;
        // same span of time as the writer, 40 ns against 30 ns
        for (int i = 0; i < TRAFFIC_CYCLES * 3 / 4; i++) begin
          @(negedge rclk);
          if (pending) begin
            compare_head("traffic data");
          end
          rd_rnd  = $urandom;
          pop     = rd_rnd[0];
          pending = pop & ~empty;
        end
        @(negedge rclk);
        if (pending) begin
          compare_head("traffic data");
        end
        pop = 1'b0;
      end
    join
    drain_all("traffic drain");
  endtask

  task automatic wrap_test;
    logic accepted;
    for (int lap = 0; lap < WRAP_LAPS; lap++) begin
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
        push_word(fifo_pkg::data_t'($urandom), accepted);
        check("wrap accept", 32'd1, 32'(accepted));
      end
      check("wrap full", 32'd1, 32'(full));
      settle;
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
        pop_word("wrap data", accepted);
        check("wrap pop accept", 32'd1, 32'(accepted));
      end
      settle;
      check("wrap empty", 32'd1, 32'(empty));
      check("wrap full released", 32'd0, 32'(full));
    end
  endtask

  task automatic flush_test;
    logic accepted;
    for (int i = 0; i < 5; i++) begin
      push_word(fifo_pkg::data_t'($urandom), accepted);
    end
    settle;
    pop_word("flush early data", accepted);
    pop_word("flush early data", accepted);
    // three words still stored when the flush hits
    @(negedge rclk);
    fflush = 1'b1;
    ref_q.delete();
    repeat (3) @(negedge rclk);
    fflush = 1'b0;
    settle;
    check("flush empty", 32'd1, 32'(empty));
    check("flush full", 32'd0, 32'(full));
    check("flush almost_full", 32'd0, 32'(almost_full));
    check("flush almost_empty", 32'd0, 32'(almost_empty));
    push_word(fifo_pkg::data_t'($urandom), accepted);
    check("flush push accept", 32'd1, 32'(accepted));
    settle;
    check("flush almost_empty one word", 32'd1, 32'(almost_empty));
    pop_word("flush first word", accepted);
    check("flush pop accept", 32'd1, 32'(accepted));
    settle;
    check("flush empty at end", 32'd1, 32'(empty));
  endtask

  initial begin
    void'($urandom(73));
    wclk   = 1'b0;
    rclk   = 1'b0;
    fflush = 1'b1;
    push   = 1'b0;
    pop    = 1'b0;
    wdata  = '0;
    repeat (8) @(posedge rclk);
    @(negedge rclk);
    fflush = 1'b0;

    reset_test;
    fill_test;
    drain_test;
    traffic_test;
    wrap_test;
    flush_test;

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  always @(posedge rclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d rclk cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

// File: filelist.f
rtl/fifo_pkg.sv
rtl/fifo_push.sv
rtl/fifo_pop.sv
rtl/fifo_ctl.sv
rtl/fifo_ram.sv
rtl/async_fifo.sv
verification/async_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator.
# Exits 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module async_fifo_tb \
  --Mdir obj_dir \
  -f filelist.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vasync_fifo_tb > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see $SIM_LOG"
  exit 1
fi

if grep -qx "TESTS PASSED" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $SIM_LOG"
  exit 1
fi
